// File: Makefile
TOP := tb_lockstep

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --assert -j 0 --timescale 1ns/1ps --top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: design/acc_core.sv
// Accumulator core

`timescale 1ns/1ps

module acc_core (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_enable_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  input  lockstep_pkg::word_t data_rdata_i,
  output logic                data_req_o,
  output logic                data_we_o,
  output lockstep_pkg::word_t data_addr_o,
  output lockstep_pkg::word_t data_wdata_o,
  output logic                alert_minor_o
);

  lockstep_pkg::core_state_e state_q, state_d;
  lockstep_pkg::word_t       addr_q;
  lockstep_pkg::word_t       acc_q;
  logic                      alert_minor_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lockstep_pkg::IDLE: begin
        if (fetch_enable_i) begin
          state_d = lockstep_pkg::RD_REQ;
        end
      end
      lockstep_pkg::RD_REQ: begin
        if (data_gnt_i) begin
          state_d = lockstep_pkg::RD_WAIT;
        end
      end
      lockstep_pkg::RD_WAIT: begin
        if (data_rvalid_i) begin
          state_d = lockstep_pkg::WR_REQ;
        end
      end
      lockstep_pkg::WR_REQ: begin
        if (data_gnt_i) begin
          state_d = lockstep_pkg::WR_WAIT;
        end
      end
      lockstep_pkg::WR_WAIT: begin
        if (data_rvalid_i) begin
          state_d = fetch_enable_i ? lockstep_pkg::RD_REQ : lockstep_pkg::IDLE;
        end
      end
      default: state_d = lockstep_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= lockstep_pkg::IDLE;
      addr_q        <= '0;
      acc_q         <= '0;
      alert_minor_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      alert_minor_q <= data_rvalid_i & data_err_i;
      // Errored read data is dropped
      if (state_q == lockstep_pkg::RD_WAIT && data_rvalid_i && !data_err_i) begin
        acc_q <= acc_q + data_rdata_i;
      end
      if (state_q == lockstep_pkg::WR_WAIT && data_rvalid_i) begin
        addr_q <= addr_q + lockstep_pkg::ADDR_STEP;
      end
    end
  end

  assign data_req_o    = (state_q == lockstep_pkg::RD_REQ) | (state_q == lockstep_pkg::WR_REQ);
  assign data_we_o     = (state_q == lockstep_pkg::WR_REQ);
  assign data_addr_o   = addr_q;
  assign data_wdata_o  = acc_q;
  assign alert_minor_o = alert_minor_q;

endmodule

// File: design/bus_intg_check.sv
// Read data integrity check

`timescale 1ns/1ps

module bus_intg_check (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                data_gnt_i,
  input  logic                data_we_i,
  input  logic                data_rvalid_i,
  input  lockstep_pkg::word_t data_rdata_i,
  input  lockstep_pkg::intg_t data_rdata_intg_i,
  output logic                bus_intg_err_o
);

  lockstep_pkg::word_t rdata_q;
  lockstep_pkg::intg_t rdata_intg_q;
  logic                rvalid_q;
  logic                we_gnt_q;
  logic                we_rsp_q;
  logic [1:0]          dec_err;

  // Response codeword
  always_ff @(posedge clk_i) begin
    rdata_q      <= data_rdata_i;
    rdata_intg_q <= data_rdata_intg_i;
  end

  // Direction of the granted request, lined up with its response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      we_gnt_q <= 1'b0;
      we_rsp_q <= 1'b0;
    end else begin
      rvalid_q <= data_rvalid_i;
      if (data_gnt_i) begin
        we_gnt_q <= data_we_i;
      end
      we_rsp_q <= we_gnt_q;
    end
  end

  secded_inv_dec u_rdata_dec (
    .data_i (rdata_q),
    .intg_i (rdata_intg_q),
    .err_o  (dec_err)
  );

  // Write responses carry no checked data
  assign bus_intg_err_o = rvalid_q & ~we_rsp_q & (|dec_err);

endmodule

// File: design/lockstep_delay.sv
// Lockstep delay line

`timescale 1ns/1ps

module lockstep_delay #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest stage
  assign q_o = stage_q[Depth-1];

endmodule

// File: design/lockstep_pkg.sv
// Lockstep shared definitions

package lockstep_pkg;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned INTG_W = 7;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [INTG_W-1:0] intg_t;

  localparam word_t ADDR_STEP     = 32'd4;
  localparam intg_t INTG_INV_MASK = 7'h2A;

  // Hsiao (39,32) parity masks, entry i covers check bit i
  localparam logic [INTG_W-1:0][DATA_W-1:0] HSIAO_MASK = {
    32'h98505586, 32'h2DCC624C, 32'hC2C1323B, 32'h31234ED1,
    32'h413D89AA, 32'hDEBA8050, 32'h2606BD25
  };

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT
  } core_state_e;

  // Plain check bits, before inversion
  function automatic intg_t secded_chk(word_t data);
    intg_t chk;
    for (int i = 0; i < INTG_W; i++) begin
      chk[i] = ^(data & HSIAO_MASK[i]);
    end
    return chk;
  endfunction

  function automatic intg_t secded_enc(word_t data);
    return secded_chk(data) ^ INTG_INV_MASK;
  endfunction

endpackage

// File: design/lockstep_top.sv
// Dual-core lockstep checker top

`timescale 1ns/1ps

module lockstep_top #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_enable_i,

  input  logic                data_req_i,
  input  logic                data_we_i,
  input  lockstep_pkg::word_t data_addr_i,
  input  lockstep_pkg::word_t data_wdata_i,

  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  lockstep_pkg::word_t data_rdata_i,
  input  lockstep_pkg::intg_t data_rdata_intg_i,
  input  logic                data_err_i,

  output lockstep_pkg::intg_t data_wdata_intg_o,
  output logic                alert_major_internal_o,
  output logic                alert_major_bus_o,
  output logic                alert_minor_o
);

  localparam int unsigned InW  = 4 + lockstep_pkg::DATA_W;
  localparam int unsigned OutW = 2 + 2 * lockstep_pkg::DATA_W;

  logic                shadow_rst_n;
  logic                cmp_en;

  logic [InW-1:0]      shadow_in_d, shadow_in_q;
  logic [OutW-1:0]     main_out_d, main_out_q;
  logic [OutW-1:0]     shadow_out_d, shadow_out_q;

  logic                sh_fetch_enable;
  logic                sh_gnt;
  logic                sh_rvalid;
  logic                sh_err;
  lockstep_pkg::word_t sh_rdata;

  logic                sh_req;
  logic                sh_we;
  lockstep_pkg::word_t sh_addr;
  lockstep_pkg::word_t sh_wdata;

  shadow_reset_gen #(
    .LockstepOffset (LockstepOffset)
  ) u_shadow_reset_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////
  // Input and output delays
  //////////////////////////////

  assign shadow_in_d = {fetch_enable_i, data_gnt_i, data_rvalid_i, data_err_i, data_rdata_i};

  lockstep_delay #(
    .Width (InW),
    .Depth (LockstepOffset)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (shadow_in_d),
    .q_o    (shadow_in_q)
  );

  assign {sh_fetch_enable, sh_gnt, sh_rvalid, sh_err, sh_rdata} = shadow_in_q;

  // One extra stage matches the shadow output register
  assign main_out_d = {data_req_i, data_we_i, data_addr_i, data_wdata_i};

  lockstep_delay #(
    .Width (OutW),
    .Depth (LockstepOffset + 1)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (main_out_d),
    .q_o    (main_out_q)
  );

  //////////////////////////////
  // Shadow core
  //////////////////////////////

  acc_core u_shadow_core (
    .clk_i          (clk_i),
    .rst_ni         (shadow_rst_n),
    .fetch_enable_i (sh_fetch_enable),
    .data_gnt_i     (sh_gnt),
    .data_rvalid_i  (sh_rvalid),
    .data_err_i     (sh_err),
    .data_rdata_i   (sh_rdata),
    .data_req_o     (sh_req),
    .data_we_o      (sh_we),
    .data_addr_o    (sh_addr),
    .data_wdata_o   (sh_wdata),
    .alert_minor_o  (alert_minor_o)
  );

  assign shadow_out_d = {sh_req, sh_we, sh_addr, sh_wdata};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_out_q <= '0;
    end else begin
      shadow_out_q <= shadow_out_d;
    end
  end

  //////////////////////////////
  // Checks and alerts
  //////////////////////////////

  bus_intg_check u_bus_intg_check (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .data_gnt_i        (data_gnt_i),
    .data_we_i         (data_we_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_rdata_i      (data_rdata_i),
    .data_rdata_intg_i (data_rdata_intg_i),
    .bus_intg_err_o    (alert_major_bus_o)
  );

  assign data_wdata_intg_o      = lockstep_pkg::secded_enc(data_wdata_i);
  assign alert_major_internal_o = cmp_en & (shadow_out_q != main_out_q);

endmodule

// File: design/secded_inv_dec.sv
// Inverted SECDED (39,32) checker

`timescale 1ns/1ps

module secded_inv_dec (
  input  lockstep_pkg::word_t data_i,
  input  lockstep_pkg::intg_t intg_i,
  output logic [1:0]          err_o
);

  lockstep_pkg::intg_t intg_plain;
  lockstep_pkg::intg_t chk_calc;
  lockstep_pkg::intg_t syndrome;
  logic                syndrome_odd;
  logic                syndrome_nz;

  // Undo the inversion on the received check bits
  assign intg_plain = intg_i ^ lockstep_pkg::INTG_INV_MASK;
  assign chk_calc   = lockstep_pkg::secded_chk(data_i);
  assign syndrome   = chk_calc ^ intg_plain;

  assign syndrome_odd = ^syndrome;
  assign syndrome_nz  = |syndrome;

  // Hsiao columns all have odd weight
  // Odd syndrome is a single-bit error, non-zero even syndrome is a double
  assign err_o[0] = syndrome_odd;
  assign err_o[1] = syndrome_nz & ~syndrome_odd;

endmodule

// File: design/shadow_reset_gen.sv
// Shadow core reset and compare enable

`timescale 1ns/1ps

module shadow_reset_gen #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  logic [CntW-1:0] cnt_q;
  logic            cnt_done;
  logic            shadow_rst_nq;
  logic            cmp_en_q;

  // Counter saturates on the last offset cycle
  assign cnt_done = (cnt_q == CntW'(LockstepOffset - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q         <= '0;
      shadow_rst_nq <= 1'b0;
      cmp_en_q      <= 1'b0;
    end else begin
      if (!cnt_done) begin
        cnt_q <= cnt_q + CntW'(1);
      end
      shadow_rst_nq <= cnt_done;
      cmp_en_q      <= shadow_rst_nq;
    end
  end

  assign shadow_rst_no = shadow_rst_nq;
  assign cmp_en_o      = cmp_en_q;

endmodule

// File: tests/tb_bus_mem.sv
// Bus memory model with fault knobs

`timescale 1ns/1ps

module tb_bus_mem #(
  parameter int unsigned Words = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                we_i,
  input  lockstep_pkg::word_t addr_i,
  input  lockstep_pkg::word_t wdata_i,
  input  logic                corrupt_intg_i,
  input  logic                inject_err_i,
  input  logic                flip_addr_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output lockstep_pkg::word_t rdata_o,
  output lockstep_pkg::intg_t rdata_intg_o,
  output logic                err_o,
  output logic                rsp_we_o,
  output lockstep_pkg::word_t addr_o
);

  localparam int unsigned IdxW = $clog2(Words);

  lockstep_pkg::word_t mem [Words];
  lockstep_pkg::word_t rdata_q;
  logic [1:0]          wait_q;
  logic                rvalid_q;
  logic                rsp_we_q;
  logic [IdxW-1:0]     idx;

  assign idx   = addr_i[IdxW+1:2];
  assign gnt_o = req_i & (wait_q == 2'd0);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Words; i++) begin
        mem[i] <= $urandom;
      end
      wait_q   <= 2'd0;
      rvalid_q <= 1'b0;
      rsp_we_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      // Response follows the grant by one cycle
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        wait_q   <= 2'($urandom_range(3, 0));
        rsp_we_q <= we_i;
        if (we_i) begin
          mem[idx] <= wdata_i;
        end else begin
          rdata_q <= mem[idx];
        end
      end else if (req_i && wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  assign rvalid_o     = rvalid_q;
  assign rsp_we_o     = rsp_we_q;
  assign rdata_o      = rdata_q;
  // One flipped check bit gives a single-bit error
  assign rdata_intg_o = lockstep_pkg::secded_enc(rdata_q) ^ {6'd0, corrupt_intg_i};
  assign err_o        = rvalid_q & inject_err_i;
  // Only the copy sent to the DUT sees the flip
  assign addr_o       = addr_i ^ {27'd0, flip_addr_i, 4'd0};

endmodule

// File: tests/tb_lockstep.sv
// Lockstep checker testbench

`timescale 1ns/1ps

module tb_lockstep;

  localparam int unsigned LockstepOffset = 3;
  localparam int unsigned WaitLimit      = 100;
  localparam int          KnobIntg       = 0;
  localparam int          KnobErr        = 1;

  logic                clk_i;
  logic                rst_ni;
  logic                fetch_enable;
  logic                corrupt_intg;
  logic                inject_err;
  logic                flip_addr;

  logic                core_req;
  logic                core_we;
  lockstep_pkg::word_t core_addr;
  lockstep_pkg::word_t core_wdata;
  lockstep_pkg::word_t dut_addr;

  logic                mem_gnt;
  logic                mem_rvalid;
  lockstep_pkg::word_t mem_rdata;
  lockstep_pkg::intg_t mem_intg;
  logic                mem_err;
  logic                mem_rsp_we;

  lockstep_pkg::intg_t wdata_intg;
  logic                alert_internal;
  logic                alert_bus;
  logic                alert_minor;

  logic [LockstepOffset:0] flip_hist;
  logic [LockstepOffset:0] err_hist;
  logic                    bad_rd_q;

  int unsigned error_count;
  int unsigned timeout_count;
  int unsigned seed_val;

  acc_core u_main_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable),
    .data_gnt_i     (mem_gnt),
    .data_rvalid_i  (mem_rvalid),
    .data_err_i     (mem_err),
    .data_rdata_i   (mem_rdata),
    .data_req_o     (core_req),
    .data_we_o      (core_we),
    .data_addr_o    (core_addr),
    .data_wdata_o   (core_wdata),
    .alert_minor_o  ()
  );

  tb_bus_mem u_mem (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (core_req),
    .we_i           (core_we),
    .addr_i         (core_addr),
    .wdata_i        (core_wdata),
    .corrupt_intg_i (corrupt_intg),
    .inject_err_i   (inject_err),
    .flip_addr_i    (flip_addr),
    .gnt_o          (mem_gnt),
    .rvalid_o       (mem_rvalid),
    .rdata_o        (mem_rdata),
    .rdata_intg_o   (mem_intg),
    .err_o          (mem_err),
    .rsp_we_o       (mem_rsp_we),
    .addr_o         (dut_addr)
  );

  lockstep_top #(
    .LockstepOffset (LockstepOffset)
  ) UUT (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .fetch_enable_i         (fetch_enable),
    .data_req_i             (core_req),
    .data_we_i              (core_we),
    .data_addr_i            (dut_addr),
    .data_wdata_i           (core_wdata),
    .data_gnt_i             (mem_gnt),
    .data_rvalid_i          (mem_rvalid),
    .data_rdata_i           (mem_rdata),
    .data_rdata_intg_i      (mem_intg),
    .data_err_i             (mem_err),
    .data_wdata_intg_o      (wdata_intg),
    .alert_major_internal_o (alert_internal),
    .alert_major_bus_o      (alert_bus),
    .alert_minor_o          (alert_minor)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #10;
      clk_i = ~clk_i;
    end
  end

  // Inverted Hsiao (39,32) check bits with one parity mask per bit
  function automatic lockstep_pkg::intg_t ref_intg(lockstep_pkg::word_t data);
    lockstep_pkg::word_t mask;
    lockstep_pkg::intg_t chk;
    for (int i = 0; i < 7; i++) begin
      case (i)
        0:       mask = 32'h2606BD25;
        1:       mask = 32'hDEBA8050;
        2:       mask = 32'h413D89AA;
        3:       mask = 32'h31234ED1;
        4:       mask = 32'hC2C1323B;
        5:       mask = 32'h2DCC624C;
        default: mask = 32'h98505586;
      endcase
      chk[i] = ^(data & mask);
    end
    return chk ^ 7'h2A;
  endfunction

  // Expected alert timing from the injected events
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flip_hist <= '0;
      err_hist  <= '0;
      bad_rd_q  <= 1'b0;
    end else begin
      flip_hist <= {flip_hist[LockstepOffset-1:0], flip_addr};
      err_hist  <= {err_hist[LockstepOffset-1:0], mem_rvalid & mem_err};
      bad_rd_q  <= mem_rvalid & corrupt_intg & ~mem_rsp_we;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  internal_alert_chk: assert property (@(negedge clk_i) disable iff (!rst_ni)
    alert_internal == flip_hist[LockstepOffset])
  else begin
    error_count++;
    $display("[ERROR] %0t alert_major_internal_o: got %b, expected %b",
             $time, alert_internal, flip_hist[LockstepOffset]);
  end

  bus_alert_chk: assert property (@(negedge clk_i) disable iff (!rst_ni)
    alert_bus == bad_rd_q)
  else begin
    error_count++;
    $display("[ERROR] %0t alert_major_bus_o: got %b, expected %b", $time, alert_bus, bad_rd_q);
  end

  minor_alert_chk: assert property (@(negedge clk_i) disable iff (!rst_ni)
    alert_minor == err_hist[LockstepOffset])
  else begin
    error_count++;
    $display("[ERROR] %0t alert_minor_o: got %b, expected %b",
             $time, alert_minor, err_hist[LockstepOffset]);
  end

  wdata_intg_chk: assert property (@(negedge clk_i) disable iff (!rst_ni)
    core_req |-> (wdata_intg == ref_intg(core_wdata)))
  else begin
    error_count++;
    $display("[ERROR] %0t data_wdata_intg_o: got %h, expected %h",
             $time, wdata_intg, ref_intg(core_wdata));
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic run_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // Sets a knob for the cycle of the next matching response
  task automatic pulse_on_response(input int knob, input logic want_we);
    int unsigned waited;
    logic        hit;
    waited = 0;
    hit    = mem_rvalid && (mem_rsp_we == want_we);
    while (!hit && waited < WaitLimit) begin
      @(posedge clk_i);
      #2;
      waited++;
      hit = mem_rvalid && (mem_rsp_we == want_we);
    end
    if (!hit) begin
      timeout_count++;
      $display("Timeout: no %s response arrived within %0d cycles",
               want_we ? "write" : "read", WaitLimit);
    end else begin
      corrupt_intg = (knob == KnobIntg);
      inject_err   = (knob == KnobErr);
      run_cycles(1);
      corrupt_intg = 1'b0;
      inject_err   = 1'b0;
    end
  endtask

  task automatic run_faults();
    run_cycles(200);
    flip_addr = 1'b1;
    run_cycles(1);
    flip_addr = 1'b0;
    run_cycles(LockstepOffset + 6);
    pulse_on_response(KnobIntg, 1'b0);
    if (timeout_count != 0) return;
    run_cycles(8);
    pulse_on_response(KnobIntg, 1'b1);
    if (timeout_count != 0) return;
    run_cycles(8);
    pulse_on_response(KnobErr, 1'b0);
    if (timeout_count != 0) return;
    run_cycles(LockstepOffset + 60);
  endtask

  initial begin : main_flow
    seed_val      = $urandom(22);
    error_count   = 0;
    timeout_count = 0;
    rst_ni        = 1'b0;
    fetch_enable  = 1'b0;
    corrupt_intg  = 1'b0;
    inject_err    = 1'b0;
    flip_addr     = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    run_cycles(1);
    fetch_enable = 1'b1;
    run_faults();
    $display("Checks finished with %0d assertion errors and %0d timeouts",
             error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/lockstep_pkg.sv
design/secded_inv_dec.sv
design/acc_core.sv
design/shadow_reset_gen.sv
design/lockstep_delay.sv
design/bus_intg_check.sv
design/lockstep_top.sv
tests/tb_bus_mem.sv
tests/tb_lockstep.sv
